// ==== decode_defines.svh ====
`ifndef DECODE_DEFINES_SVH
`define DECODE_DEFINES_SVH

`define DATA_W   32
`define REG_AW   5
`define REG_N    32
`define ALU_OP_W 12

// one-hot alu operation bit positions
`define ALU_ADD  0
`define ALU_SUB  1
`define ALU_SLT  2
`define ALU_SLTU 3
`define ALU_AND  4
`define ALU_NOR  5
`define ALU_OR   6
`define ALU_XOR  7
`define ALU_SLL  8
`define ALU_SRL  9
`define ALU_SRA  10
`define ALU_LUI  11

// inst[31:26]
`define OP6_ALU       6'h00
`define OP6_LU12I     6'h05
`define OP6_PCADDU12I 6'h07
`define OP6_MEM       6'h0a
`define OP6_JIRL      6'h13
`define OP6_B         6'h14
`define OP6_BL        6'h15
`define OP6_BEQ       6'h16
`define OP6_BNE       6'h17
`define OP6_BLT       6'h18
`define OP6_BGE       6'h19
`define OP6_BLTU      6'h1a
`define OP6_BGEU      6'h1b

// inst[25:22]
`define OP4_REG   4'h0
`define OP4_SHIFT 4'h1
`define OP4_LD_W  4'h2
`define OP4_ST_W  4'h6
`define OP4_SLTI  4'h8
`define OP4_SLTUI 4'h9
`define OP4_ADDI  4'ha
`define OP4_ANDI  4'hd
`define OP4_ORI   4'he
`define OP4_XORI  4'hf

// inst[21:20]
`define OP2_REG   2'h1
`define OP2_SHIFT 2'h0

// inst[19:15]
`define OP5_ADD  5'h00
`define OP5_SUB  5'h02
`define OP5_SLT  5'h04
`define OP5_SLTU 5'h05
`define OP5_NOR  5'h08
`define OP5_AND  5'h09
`define OP5_OR   5'h0a
`define OP5_XOR  5'h0b
`define OP5_SLL  5'h0e
`define OP5_SRL  5'h0f
`define OP5_SRA  5'h10
`define OP5_SLLI 5'h01
`define OP5_SRLI 5'h09
`define OP5_SRAI 5'h11

`endif

// ==== decode_pkg.sv ====
`include "decode_defines.svh"

package decode_pkg;

    typedef struct packed {
        logic [5:0]         op6;
        logic [3:0]         op4;
        logic [1:0]         op2;
        logic [4:0]         op5;
        logic [`REG_AW-1:0] rk;
        logic [`REG_AW-1:0] rj;
        logic [`REG_AW-1:0] rd;
    } reg_view_t;

    // 12 and 20 bit immediates are slices of imm16/rj
    typedef struct packed {
        logic [5:0]         op6;
        logic [15:0]        imm16;
        logic [`REG_AW-1:0] rj;
        logic [`REG_AW-1:0] rd;
    } imm_view_t;

    typedef union packed {
        reg_view_t reg_view;
        imm_view_t imm_view;
    } inst_word_u;

    typedef struct packed {
        inst_word_u         inst;
        logic [`DATA_W-1:0] pc;
    } fetch_pkt_t;

    // dest zero means nothing on offer
    typedef struct packed {
        logic               valid;
        logic [`REG_AW-1:0] dest;
        logic [`DATA_W-1:0] value;
    } fwd_pkt_t;

    typedef struct packed {
        logic               we;
        logic [`REG_AW-1:0] addr;
        logic [`DATA_W-1:0] data;
    } wb_pkt_t;

    typedef struct packed {
        logic beq;
        logic bne;
        logic blt;
        logic bge;
        logic bltu;
        logic bgeu;
        logic jump_pc;
        logic jump_reg;
    } br_kind_t;

    typedef struct packed {
        logic [`ALU_OP_W-1:0] alu_op;
        logic                 src1_is_pc;
        logic                 src2_is_imm;
        logic                 src2_is_rd;
        logic                 res_from_mem;
        logic                 mem_we;
        logic                 gr_we;
        logic [`REG_AW-1:0]   dest;
        br_kind_t             br;
    } dec_ctrl_t;

    typedef struct packed {
        logic               taken;
        logic [`DATA_W-1:0] target;
    } br_pkt_t;

    typedef struct packed {
        logic [`ALU_OP_W-1:0] alu_op;
        logic [`DATA_W-1:0]   alu_src1;
        logic [`DATA_W-1:0]   alu_src2;
        logic [`DATA_W-1:0]   store_data;
        logic                 res_from_mem;
        logic                 mem_we;
        logic                 gr_we;
        logic [`REG_AW-1:0]   dest;
        logic [`DATA_W-1:0]   pc;
    } issue_pkt_t;

endpackage

// ==== fetch_latch.sv ====
`timescale 1ns/1ps
`include "decode_defines.svh"

module fetch_latch import decode_pkg::*; (
    input  logic       clk,
    input  logic       reset,
    input  logic       fs_valid,
    input  fetch_pkt_t fs_pkt,
    input  logic       allowin,
    input  logic       kill,
    output logic       valid,
    output fetch_pkt_t pkt
);

    // a taken branch drops whatever fetch offers behind it
    always_ff @(posedge clk) begin
        if (reset) begin
            valid <= 1'b0;
        end else if (allowin) begin
            valid <= fs_valid & ~kill;
        end
    end

    always_ff @(posedge clk) begin
        if (allowin && fs_valid) begin
            pkt <= fs_pkt;
        end
    end

endmodule

// ==== inst_decoder.sv ====
`timescale 1ns/1ps
`include "decode_defines.svh"

module inst_decoder import decode_pkg::*; (
    input  inst_word_u         inst,
    output dec_ctrl_t          ctrl,
    output logic [`DATA_W-1:0] imm,
    output logic [`DATA_W-1:0] br_offs,
    output logic [`REG_AW-1:0] raddr1,
    output logic [`REG_AW-1:0] raddr2
);

    logic [5:0]  op6;
    logic [3:0]  op4;
    logic [4:0]  op5;
    logic        grp_reg;
    logic        grp_shift;
    logic        grp_imm;
    logic        inst_add_w, inst_sub_w, inst_slt, inst_sltu;
    logic        inst_and, inst_or, inst_nor, inst_xor;
    logic        inst_sll_w, inst_srl_w, inst_sra_w;
    logic        inst_slli_w, inst_srli_w, inst_srai_w;
    logic        inst_addi_w, inst_slti, inst_sltui, inst_andi, inst_ori, inst_xori;
    logic        inst_lu12i_w, inst_pcaddu12i, inst_ld_w, inst_st_w;
    logic        inst_b, inst_bl, inst_jirl;
    logic        cond_br;
    logic        need_ui12, need_si20, src2_is_4;
    logic        reads_rj, reads_r2;
    logic [11:0] i12;
    logic [15:0] i16;
    logic [19:0] i20;
    logic [25:0] i26;

    assign op6 = inst.reg_view.op6;
    assign op4 = inst.reg_view.op4;
    assign op5 = inst.reg_view.op5;

    assign grp_reg   = (op6 == `OP6_ALU) && (op4 == `OP4_REG) && (inst.reg_view.op2 == `OP2_REG);
    assign grp_shift = (op6 == `OP6_ALU) && (op4 == `OP4_SHIFT)
                       && (inst.reg_view.op2 == `OP2_SHIFT);
    assign grp_imm   = (op6 == `OP6_ALU);

    assign inst_add_w  = grp_reg && (op5 == `OP5_ADD);
    assign inst_sub_w  = grp_reg && (op5 == `OP5_SUB);
    assign inst_slt    = grp_reg && (op5 == `OP5_SLT);
    assign inst_sltu   = grp_reg && (op5 == `OP5_SLTU);
    assign inst_nor    = grp_reg && (op5 == `OP5_NOR);
    assign inst_and    = grp_reg && (op5 == `OP5_AND);
    assign inst_or     = grp_reg && (op5 == `OP5_OR);
    assign inst_xor    = grp_reg && (op5 == `OP5_XOR);
    assign inst_sll_w  = grp_reg && (op5 == `OP5_SLL);
    assign inst_srl_w  = grp_reg && (op5 == `OP5_SRL);
    assign inst_sra_w  = grp_reg && (op5 == `OP5_SRA);
    assign inst_slli_w = grp_shift && (op5 == `OP5_SLLI);
    assign inst_srli_w = grp_shift && (op5 == `OP5_SRLI);
    assign inst_srai_w = grp_shift && (op5 == `OP5_SRAI);

    assign inst_addi_w = grp_imm && (op4 == `OP4_ADDI);
    assign inst_slti   = grp_imm && (op4 == `OP4_SLTI);
    assign inst_sltui  = grp_imm && (op4 == `OP4_SLTUI);
    assign inst_andi   = grp_imm && (op4 == `OP4_ANDI);
    assign inst_ori    = grp_imm && (op4 == `OP4_ORI);
    assign inst_xori   = grp_imm && (op4 == `OP4_XORI);
    assign inst_ld_w   = (op6 == `OP6_MEM) && (op4 == `OP4_LD_W);
    assign inst_st_w   = (op6 == `OP6_MEM) && (op4 == `OP4_ST_W);

    // inst[25] must be clear for the 20-bit forms
    assign inst_lu12i_w   = (op6 == `OP6_LU12I) && !inst.imm_view.imm16[15];
    assign inst_pcaddu12i = (op6 == `OP6_PCADDU12I) && !inst.imm_view.imm16[15];

    assign inst_jirl = (op6 == `OP6_JIRL);
    assign inst_b    = (op6 == `OP6_B);
    assign inst_bl   = (op6 == `OP6_BL);

    assign ctrl.br.beq      = (op6 == `OP6_BEQ);
    assign ctrl.br.bne      = (op6 == `OP6_BNE);
    assign ctrl.br.blt      = (op6 == `OP6_BLT);
    assign ctrl.br.bge      = (op6 == `OP6_BGE);
    assign ctrl.br.bltu     = (op6 == `OP6_BLTU);
    assign ctrl.br.bgeu     = (op6 == `OP6_BGEU);
    assign ctrl.br.jump_pc  = inst_b | inst_bl;
    assign ctrl.br.jump_reg = inst_jirl;

    assign cond_br = ctrl.br.beq | ctrl.br.bne | ctrl.br.blt | ctrl.br.bge
                     | ctrl.br.bltu | ctrl.br.bgeu;

    assign ctrl.alu_op[`ALU_ADD]  = inst_add_w | inst_addi_w | inst_ld_w | inst_st_w
                                    | inst_jirl | inst_bl | inst_pcaddu12i;
    assign ctrl.alu_op[`ALU_SUB]  = inst_sub_w;
    assign ctrl.alu_op[`ALU_SLT]  = inst_slt | inst_slti;
    assign ctrl.alu_op[`ALU_SLTU] = inst_sltu | inst_sltui;
    assign ctrl.alu_op[`ALU_AND]  = inst_and | inst_andi;
    assign ctrl.alu_op[`ALU_NOR]  = inst_nor;
    assign ctrl.alu_op[`ALU_OR]   = inst_or | inst_ori;
    assign ctrl.alu_op[`ALU_XOR]  = inst_xor | inst_xori;
    assign ctrl.alu_op[`ALU_SLL]  = inst_sll_w | inst_slli_w;
    assign ctrl.alu_op[`ALU_SRL]  = inst_srl_w | inst_srli_w;
    assign ctrl.alu_op[`ALU_SRA]  = inst_sra_w | inst_srai_w;
    assign ctrl.alu_op[`ALU_LUI]  = inst_lu12i_w;

    assign i12 = inst.imm_view.imm16[11:0];
    assign i16 = inst.imm_view.imm16;
    assign i20 = {inst.imm_view.imm16[14:0], inst.imm_view.rj};
    assign i26 = {inst.imm_view.rj, inst.imm_view.rd, inst.imm_view.imm16};

    assign need_ui12 = inst_andi | inst_ori | inst_xori;
    assign need_si20 = inst_lu12i_w | inst_pcaddu12i;
    assign src2_is_4 = inst_jirl | inst_bl;

    // shift amounts ride in the low bits of the si12 form
    assign imm = src2_is_4 ? `DATA_W'd4 :
                 need_ui12 ? {20'b0, i12} :
                 need_si20 ? {i20, 12'b0} :
                             {{20{i12[11]}}, i12};

    assign br_offs = ctrl.br.jump_pc ? {{4{i26[25]}}, i26, 2'b0} :
                                       {{14{i16[15]}}, i16, 2'b0};

    assign ctrl.src1_is_pc   = inst_jirl | inst_bl | inst_pcaddu12i;
    assign ctrl.src2_is_imm  = grp_shift | inst_addi_w | inst_slti | inst_sltui | need_ui12
                               | need_si20 | inst_ld_w | inst_st_w | src2_is_4;
    assign ctrl.src2_is_rd   = cond_br | inst_st_w;
    assign ctrl.res_from_mem = inst_ld_w;
    assign ctrl.mem_we       = inst_st_w;
    assign ctrl.gr_we        = ~inst_st_w & ~cond_br & ~inst_b;
    assign ctrl.dest         = inst_bl ? `REG_AW'd1 : inst.reg_view.rd;

    // an operand that is not read reports r0, so it never forwards or stalls
    assign reads_rj = ~(inst_b | inst_bl | need_si20);
    assign reads_r2 = grp_reg | ctrl.src2_is_rd;

    assign raddr1 = reads_rj ? inst.reg_view.rj : '0;
    assign raddr2 = !reads_r2        ? '0 :
                    ctrl.src2_is_rd ? inst.reg_view.rd : inst.reg_view.rk;

endmodule

// ==== reg_file.sv ====
`timescale 1ns/1ps
`include "decode_defines.svh"

module reg_file import decode_pkg::*; (
    input  logic               clk,
    input  logic [`REG_AW-1:0] raddr1,
    input  logic [`REG_AW-1:0] raddr2,
    output logic [`DATA_W-1:0] rdata1,
    output logic [`DATA_W-1:0] rdata2,
    input  wb_pkt_t            wb
);

    logic [`DATA_W-1:0] regs [`REG_N];

    always_ff @(posedge clk) begin
        if (wb.we && (wb.addr != '0)) begin
            regs[wb.addr] <= wb.data;
        end
    end

    // r0 reads as zero
    assign rdata1 = (raddr1 == '0) ? '0 : regs[raddr1];
    assign rdata2 = (raddr2 == '0) ? '0 : regs[raddr2];

endmodule

// ==== operand_bypass.sv ====
`timescale 1ns/1ps
`include "decode_defines.svh"

module operand_bypass import decode_pkg::*; (
    input  logic [`REG_AW-1:0] raddr1,
    input  logic [`REG_AW-1:0] raddr2,
    input  logic [`DATA_W-1:0] rdata1,
    input  logic [`DATA_W-1:0] rdata2,
    input  fwd_pkt_t           es_fwd,
    input  fwd_pkt_t           ms_fwd,
    input  fwd_pkt_t           ws_fwd,
    input  logic               es_is_load,
    output logic [`DATA_W-1:0] rj_value,
    output logic [`DATA_W-1:0] rkd_value,
    output logic               stall
);

    // youngest producer wins
    function automatic logic [`DATA_W-1:0] pick(
        input logic [`REG_AW-1:0] addr,
        input logic [`DATA_W-1:0] rdata,
        input fwd_pkt_t           es,
        input fwd_pkt_t           ms,
        input fwd_pkt_t           ws
    );
        if (addr == '0) begin
            return rdata;
        end else if (es.valid && (es.dest == addr)) begin
            return es.value;
        end else if (ms.valid && (ms.dest == addr)) begin
            return ms.value;
        end else if (ws.valid && (ws.dest == addr)) begin
            return ws.value;
        end
        return rdata;
    endfunction

    assign rj_value  = pick(raddr1, rdata1, es_fwd, ms_fwd, ws_fwd);
    assign rkd_value = pick(raddr2, rdata2, es_fwd, ms_fwd, ws_fwd);

    // load data is not ready until mem
    assign stall = es_is_load && (es_fwd.dest != '0)
                   && ((es_fwd.dest == raddr1) || (es_fwd.dest == raddr2));

endmodule

// ==== branch_unit.sv ====
`timescale 1ns/1ps
`include "decode_defines.svh"

module branch_unit import decode_pkg::*; (
    input  dec_ctrl_t          ctrl,
    input  logic               valid,
    input  logic               ready_go,
    input  logic [`DATA_W-1:0] pc,
    input  logic [`DATA_W-1:0] br_offs,
    input  logic [`DATA_W-1:0] imm,
    input  logic [`DATA_W-1:0] rj_value,
    input  logic [`DATA_W-1:0] rkd_value,
    output br_pkt_t            br
);

    logic               eq;
    logic               lt;
    logic               ltu;
    logic               cond;
    logic               is_branch;
    logic [`DATA_W-1:0] base;
    logic [`DATA_W-1:0] offs;

    assign eq  = (rj_value == rkd_value);
    assign lt  = ($signed(rj_value) < $signed(rkd_value));
    assign ltu = (rj_value < rkd_value);

    assign cond = (ctrl.br.beq  &  eq)  | (ctrl.br.bne  & ~eq)
                | (ctrl.br.blt  &  lt)  | (ctrl.br.bge  & ~lt)
                | (ctrl.br.bltu &  ltu) | (ctrl.br.bgeu & ~ltu)
                | ctrl.br.jump_pc | ctrl.br.jump_reg;

    // jirl keeps 4 in imm for the link, its offset lives in br_offs
    assign is_branch = |ctrl.br;
    assign base      = ctrl.br.jump_reg ? rj_value : pc;
    // non-branch slots reuse the adder for pc plus imm
    assign offs      = is_branch ? br_offs : imm;

    assign br.taken  = valid & ready_go & cond;
    assign br.target = base + offs;

endmodule

// ==== issue_control.sv ====
`timescale 1ns/1ps
`include "decode_defines.svh"

module issue_control import decode_pkg::*; (
    input  dec_ctrl_t          ctrl,
    input  logic               valid,
    input  logic               stall,
    input  logic               es_allowin,
    input  logic [`DATA_W-1:0] pc,
    input  logic [`DATA_W-1:0] imm,
    input  logic [`DATA_W-1:0] rj_value,
    input  logic [`DATA_W-1:0] rkd_value,
    output logic               ready_go,
    output logic               allowin,
    output logic               out_valid,
    output issue_pkt_t         issue_pkt
);

    assign ready_go  = ~stall;
    assign allowin   = ~valid | (ready_go & es_allowin);
    assign out_valid = valid & ready_go;

    assign issue_pkt.alu_op       = ctrl.alu_op;
    assign issue_pkt.alu_src1     = ctrl.src1_is_pc ? pc : rj_value;
    assign issue_pkt.alu_src2     = ctrl.src2_is_imm ? imm : rkd_value;
    // stores read rd through the second port
    assign issue_pkt.store_data   = rkd_value;
    assign issue_pkt.res_from_mem = ctrl.res_from_mem;
    assign issue_pkt.mem_we       = ctrl.mem_we;
    assign issue_pkt.gr_we        = ctrl.gr_we;
    assign issue_pkt.dest         = ctrl.dest;
    assign issue_pkt.pc           = pc;

endmodule

// ==== decode_stage.sv ====
`timescale 1ns/1ps
`include "decode_defines.svh"

module decode_stage import decode_pkg::*; (
    input  logic       clk,
    input  logic       reset,
    input  logic       fs_valid,
    input  fetch_pkt_t fs_pkt,
    output logic       ds_allowin,
    input  logic       es_allowin,
    output logic       ds_valid_out,
    output issue_pkt_t issue_pkt,
    output br_pkt_t    br,
    input  fwd_pkt_t   es_fwd,
    input  fwd_pkt_t   ms_fwd,
    input  fwd_pkt_t   ws_fwd,
    input  logic       es_is_load,
    input  wb_pkt_t    wb
);

    logic               ds_valid;
    fetch_pkt_t         ds_pkt;
    dec_ctrl_t          ctrl;
    logic [`DATA_W-1:0] imm;
    logic [`DATA_W-1:0] br_offs;
    logic [`REG_AW-1:0] raddr1;
    logic [`REG_AW-1:0] raddr2;
    logic [`DATA_W-1:0] rdata1;
    logic [`DATA_W-1:0] rdata2;
    logic [`DATA_W-1:0] rj_value;
    logic [`DATA_W-1:0] rkd_value;
    logic               stall;
    logic               ready_go;

    fetch_latch fetch_latch_i (
        .clk      (clk),
        .reset    (reset),
        .fs_valid (fs_valid),
        .fs_pkt   (fs_pkt),
        .allowin  (ds_allowin),
        .kill     (br.taken),
        .valid    (ds_valid),
        .pkt      (ds_pkt)
    );

    inst_decoder inst_decoder_i (
        .inst    (ds_pkt.inst),
        .ctrl    (ctrl),
        .imm     (imm),
        .br_offs (br_offs),
        .raddr1  (raddr1),
        .raddr2  (raddr2)
    );

    reg_file reg_file_i (
        .clk    (clk),
        .raddr1 (raddr1),
        .raddr2 (raddr2),
        .rdata1 (rdata1),
        .rdata2 (rdata2),
        .wb     (wb)
    );

    operand_bypass operand_bypass_i (
        .raddr1     (raddr1),
        .raddr2     (raddr2),
        .rdata1     (rdata1),
        .rdata2     (rdata2),
        .es_fwd     (es_fwd),
        .ms_fwd     (ms_fwd),
        .ws_fwd     (ws_fwd),
        .es_is_load (es_is_load),
        .rj_value   (rj_value),
        .rkd_value  (rkd_value),
        .stall      (stall)
    );

    branch_unit branch_unit_i (
        .ctrl      (ctrl),
        .valid     (ds_valid),
        .ready_go  (ready_go),
        .pc        (ds_pkt.pc),
        .br_offs   (br_offs),
        .imm       (imm),
        .rj_value  (rj_value),
        .rkd_value (rkd_value),
        .br        (br)
    );

    issue_control issue_control_i (
        .ctrl       (ctrl),
        .valid      (ds_valid),
        .stall      (stall),
        .es_allowin (es_allowin),
        .pc         (ds_pkt.pc),
        .imm        (imm),
        .rj_value   (rj_value),
        .rkd_value  (rkd_value),
        .ready_go   (ready_go),
        .allowin    (ds_allowin),
        .out_valid  (ds_valid_out),
        .issue_pkt  (issue_pkt)
    );

endmodule

// ==== tb_decode_vectors.svh ====
// a row opens with new_row(hold, inst, pc) and may add side(es, ms, ws, es_is_load,
// es_allowin), expect_br(taken, target) and flag overrides; expect_issue(alu_op, src1, src2,
// store_data, dest, gr_we, {res_from_mem, mem_we}) closes and appends it
new_row(1'b0, enc_3r(`OP5_ADD, 5'd2, 5'd1, 5'd7), 32'h1c00_0000);
expect_issue(A_ADD, 32'h0000_0010, 32'h0000_0003, 32'h0000_0003, 5'd7, 1'b1, 2'b00);
new_row(1'b0, enc_3r(`OP5_SUB, 5'd1, 5'd5, 5'd8), 32'h1c00_0004);
expect_issue(A_SUB, 32'h1234_5678, 32'h0000_0010, 32'h0000_0010, 5'd8, 1'b1, 2'b00);
new_row(1'b0, enc_3r(`OP5_SLT, 5'd2, 5'd3, 5'd9), 32'h1c00_0008);
expect_issue(A_SLT, 32'hffff_fff0, 32'h0000_0003, 32'h0000_0003, 5'd9, 1'b1, 2'b00);
new_row(1'b0, enc_3r(`OP5_SLL, 5'd2, 5'd5, 5'd10), 32'h1c00_000c);
expect_issue(A_SLL, 32'h1234_5678, 32'h0000_0003, 32'h0000_0003, 5'd10, 1'b1, 2'b00);
// immediate forms
new_row(1'b0, enc_2ri12(`OP6_ALU, `OP4_ADDI, 12'hffc, 5'd1, 5'd11), 32'h1c00_0010);
expect_issue(A_ADD, 32'h0000_0010, 32'hffff_fffc, 32'h0, 5'd11, 1'b1, 2'b00);
new_row(1'b0, enc_2ri12(`OP6_ALU, `OP4_ORI, 12'h8f0, 5'd1, 5'd12), 32'h1c00_0014);
expect_issue(A_OR, 32'h0000_0010, 32'h0000_08f0, 32'h0, 5'd12, 1'b1, 2'b00);
new_row(1'b0, enc_1ri20(`OP6_LU12I, 20'habcde, 5'd13), 32'h1c00_0018);
expect_issue(A_LUI, 32'h0, 32'habcd_e000, 32'h0, 5'd13, 1'b1, 2'b00);
new_row(1'b0, enc_1ri20(`OP6_PCADDU12I, 20'h00001, 5'd14), 32'h1c00_0200);
expect_issue(A_ADD, 32'h1c00_0200, 32'h0000_1000, 32'h0, 5'd14, 1'b1, 2'b00);
new_row(1'b0, enc_2ri12(`OP6_MEM, `OP4_LD_W, 12'h008, 5'd6, 5'd15), 32'h1c00_0204);
expect_issue(A_ADD, 32'h0000_1000, 32'h0000_0008, 32'h0, 5'd15, 1'b1, 2'b10);
new_row(1'b0, enc_2ri12(`OP6_MEM, `OP4_ST_W, 12'h00c, 5'd6, 5'd5), 32'h1c00_0208);
expect_issue(A_ADD, 32'h0000_1000, 32'h0000_000c, 32'h1234_5678, 5'd5, 1'b0, 2'b01);
new_row(1'b0, enc_shift(`OP5_SLLI, 5'd3, 5'd5, 5'd16), 32'h1c00_020c);
expect_issue(A_SLL, 32'h1234_5678, 32'h0000_0023, 32'h0, 5'd16, 1'b1, 2'b00);
// forwarding priority
new_row(1'b0, enc_3r(`OP5_ADD, 5'd2, 5'd1, 5'd17), 32'h1c00_0210);
side(offer(5'd1, 32'haaaa_0001), offer(5'd1, 32'hbbbb_0002), offer(5'd1, 32'hcccc_0003),
     1'b0, 1'b1);
expect_issue(A_ADD, 32'haaaa_0001, 32'h0000_0003, 32'h0000_0003, 5'd17, 1'b1, 2'b00);
new_row(1'b0, enc_3r(`OP5_ADD, 5'd2, 5'd1, 5'd17), 32'h1c00_0214);
side(NO_FWD, NO_FWD, offer(5'd1, 32'hcccc_0003), 1'b0, 1'b1);
expect_issue(A_ADD, 32'hcccc_0003, 32'h0000_0003, 32'h0000_0003, 5'd17, 1'b1, 2'b00);
new_row(1'b0, enc_3r(`OP5_ADD, 5'd2, 5'd0, 5'd17), 32'h1c00_0218);
side(offer(5'd0, 32'hdead_beef), NO_FWD, NO_FWD, 1'b0, 1'b1);
expect_issue(A_ADD, 32'h0, 32'h0000_0003, 32'h0000_0003, 5'd17, 1'b1, 2'b00);
// load-use stall then release
new_row(1'b0, enc_3r(`OP5_ADD, 5'd2, 5'd1, 5'd18), 32'h1c00_021c);
side(offer(5'd2, 32'h0000_0077), NO_FWD, NO_FWD, 1'b1, 1'b1);
cur.exp_valid = 1'b0;
cur.exp_allowin = 1'b0;
expect_issue(A_ADD, 32'h0000_0010, 32'h0000_0077, 32'h0000_0077, 5'd18, 1'b1, 2'b00);
new_row(1'b1, enc_3r(`OP5_ADD, 5'd2, 5'd1, 5'd18), 32'h1c00_021c);
side(offer(5'd2, 32'h0000_0077), NO_FWD, NO_FWD, 1'b0, 1'b1);
expect_issue(A_ADD, 32'h0000_0010, 32'h0000_0077, 32'h0000_0077, 5'd18, 1'b1, 2'b00);
// branches
new_row(1'b0, enc_2ri16(`OP6_BEQ, 16'h0004, 5'd1, 5'd4), 32'h1c00_0300);
expect_br(1'b1, 32'h1c00_0310);
expect_issue(A_NONE, 32'h0000_0010, 32'h0000_0010, 32'h0000_0010, 5'd4, 1'b0, 2'b00);
new_row(1'b0, enc_2ri16(`OP6_BNE, 16'h0004, 5'd1, 5'd4), 32'h1c00_0340);
expect_issue(A_NONE, 32'h0000_0010, 32'h0000_0010, 32'h0000_0010, 5'd4, 1'b0, 2'b00);
new_row(1'b0, enc_2ri16(`OP6_BNE, 16'hfffe, 5'd1, 5'd2), 32'h1c00_0400);
expect_br(1'b1, 32'h1c00_03f8);
expect_issue(A_NONE, 32'h0000_0010, 32'h0000_0003, 32'h0000_0003, 5'd2, 1'b0, 2'b00);
new_row(1'b0, enc_2ri16(`OP6_BLT, 16'h0008, 5'd3, 5'd2), 32'h1c00_0500);
expect_br(1'b1, 32'h1c00_0520);
expect_issue(A_NONE, 32'hffff_fff0, 32'h0000_0003, 32'h0000_0003, 5'd2, 1'b0, 2'b00);
new_row(1'b0, enc_2ri16(`OP6_BLTU, 16'h0008, 5'd3, 5'd2), 32'h1c00_0540);
expect_issue(A_NONE, 32'hffff_fff0, 32'h0000_0003, 32'h0000_0003, 5'd2, 1'b0, 2'b00);
new_row(1'b0, enc_i26(`OP6_B, 26'h000_0040), 32'h1c00_0600);
expect_br(1'b1, 32'h1c00_0700);
expect_issue(A_NONE, 32'h0, 32'h0, 32'h0, 5'd0, 1'b0, 2'b00);
new_row(1'b0, enc_i26(`OP6_BL, 26'h3ff_ffff), 32'h1c00_0700);
expect_br(1'b1, 32'h1c00_06fc);
expect_issue(A_ADD, 32'h1c00_0700, 32'h0000_0004, 32'h0, 5'd1, 1'b1, 2'b00);
new_row(1'b0, enc_2ri16(`OP6_JIRL, 16'h0010, 5'd6, 5'd20), 32'h1c00_0800);
expect_br(1'b1, 32'h0000_1040);
expect_issue(A_ADD, 32'h1c00_0800, 32'h0000_0004, 32'h0, 5'd20, 1'b1, 2'b00);
// back-pressure held for two cycles
new_row(1'b0, enc_3r(`OP5_ADD, 5'd1, 5'd5, 5'd21), 32'h1c00_0900);
side(NO_FWD, NO_FWD, NO_FWD, 1'b0, 1'b0);
cur.exp_allowin = 1'b0;
expect_issue(A_ADD, 32'h1234_5678, 32'h0000_0010, 32'h0000_0010, 5'd21, 1'b1, 2'b00);
new_row(1'b1, enc_3r(`OP5_ADD, 5'd1, 5'd5, 5'd21), 32'h1c00_0900);
side(NO_FWD, NO_FWD, NO_FWD, 1'b0, 1'b0);
cur.exp_allowin = 1'b0;
expect_issue(A_ADD, 32'h1234_5678, 32'h0000_0010, 32'h0000_0010, 5'd21, 1'b1, 2'b00);
new_row(1'b1, enc_3r(`OP5_ADD, 5'd1, 5'd5, 5'd21), 32'h1c00_0900);
expect_issue(A_ADD, 32'h1234_5678, 32'h0000_0010, 32'h0000_0010, 5'd21, 1'b1, 2'b00);

// ==== tb_decode_stage.sv ====
`timescale 1ns/1ps
`include "decode_defines.svh"

module tb_decode_stage import decode_pkg::*; ();

    localparam int RESET_CYCLES = 16;
    localparam logic [11:0] A_NONE = 12'd0;
    localparam logic [11:0] A_ADD = 12'd1 << `ALU_ADD;
    localparam logic [11:0] A_SUB = 12'd1 << `ALU_SUB;
    localparam logic [11:0] A_SLT = 12'd1 << `ALU_SLT;
    localparam logic [11:0] A_OR  = 12'd1 << `ALU_OR;
    localparam logic [11:0] A_SLL = 12'd1 << `ALU_SLL;
    localparam logic [11:0] A_LUI = 12'd1 << `ALU_LUI;
    localparam fwd_pkt_t NO_FWD = '0;

    typedef struct {
        logic        hold;
        logic [31:0] inst;
        logic [31:0] pc;
        fwd_pkt_t    es;
        fwd_pkt_t    ms;
        fwd_pkt_t    ws;
        logic        load;
        logic        allow;
        logic        exp_valid;
        logic        exp_allowin;
        logic [11:0] exp_op;
        logic [31:0] exp_src1;
        logic [31:0] exp_src2;
        logic [31:0] exp_store;
        logic [4:0]  exp_dest;
        logic        exp_gr_we;
        logic [1:0]  exp_mem;
        logic        exp_taken;
        logic [31:0] exp_target;
    } row_t;

    logic       clk = 1'b0;
    logic       reset;
    logic       fs_valid;
    fetch_pkt_t fs_pkt;
    logic       ds_allowin;
    logic       es_allowin;
    logic       ds_valid_out;
    issue_pkt_t issue_pkt;
    br_pkt_t    br;
    fwd_pkt_t   es_fwd;
    fwd_pkt_t   ms_fwd;
    fwd_pkt_t   ws_fwd;
    logic       es_is_load;
    wb_pkt_t    wb;

    row_t rows[$];
    row_t cur;
    int   cur_idx;
    int   row_errs;
    int   passed = 0;
    int   failed = 0;
    int   cycles = 0;
    int   limit = 0;

    decode_stage decode_stage_i (.*);

    always #2 clk = ~clk;

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (limit != 0 && cycles >= limit) begin
            $display("timeout after %0d cycles, the table did not finish", cycles);
            $display("=== FAIL ===");
            $finish;
        end
    end

    // one encoder per instruction format
    function automatic logic [31:0] enc_3r(input logic [4:0] op5, rk, rj, rd);
        return {`OP6_ALU, `OP4_REG, `OP2_REG, op5, rk, rj, rd};
    endfunction

    function automatic logic [31:0] enc_shift(input logic [4:0] op5, ui5, rj, rd);
        return {`OP6_ALU, `OP4_SHIFT, `OP2_SHIFT, op5, ui5, rj, rd};
    endfunction

    function automatic logic [31:0] enc_2ri12(input logic [5:0] op6, input logic [3:0] op4,
                                              input logic [11:0] i12, input logic [4:0] rj, rd);
        return {op6, op4, i12, rj, rd};
    endfunction

    function automatic logic [31:0] enc_1ri20(input logic [5:0] op6, input logic [19:0] i20,
                                              input logic [4:0] rd);
        return {op6, 1'b0, i20, rd};
    endfunction

    function automatic logic [31:0] enc_2ri16(input logic [5:0] op6, input logic [15:0] i16,
                                              input logic [4:0] rj, rd);
        return {op6, i16, rj, rd};
    endfunction

    // offs[15:0] sits above rj and offs[25:16] takes the rj and rd slots
    function automatic logic [31:0] enc_i26(input logic [5:0] op6, input logic [25:0] offs);
        return {op6, offs[15:0], offs[25:16]};
    endfunction

    function automatic fwd_pkt_t offer(input logic [4:0] dest, input logic [31:0] value);
        return '{valid: 1'b1, dest: dest, value: value};
    endfunction

    task automatic new_row(input logic hold, input logic [31:0] inst, input logic [31:0] pc);
        cur = '{default: '0};
        cur.hold = hold;
        cur.inst = inst;
        cur.pc = pc;
        cur.allow = 1'b1;
        cur.exp_valid = 1'b1;
        cur.exp_allowin = 1'b1;
    endtask

    task automatic side(input fwd_pkt_t es, ms, ws, input logic load, allow);
        cur.es = es;
        cur.ms = ms;
        cur.ws = ws;
        cur.load = load;
        cur.allow = allow;
    endtask

    task automatic expect_br(input logic taken, input logic [31:0] target);
        cur.exp_taken = taken;
        cur.exp_target = target;
    endtask

    task automatic expect_issue(input logic [11:0] op, input logic [31:0] src1, src2, store,
                                input logic [4:0] dest, input logic gr_we,
                                input logic [1:0] mem);
        cur.exp_op = op;
        cur.exp_src1 = src1;
        cur.exp_src2 = src2;
        cur.exp_store = store;
        cur.exp_dest = dest;
        cur.exp_gr_we = gr_we;
        cur.exp_mem = mem;
        rows.push_back(cur);
    endtask

    task automatic build_table();
        `include "tb_decode_vectors.svh"
    endtask

    task automatic compare(input string what, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            $display("error at %0d ns: row %0d %s got %h expected %h",
                     $time, cur_idx, what, got, exp);
            row_errs++;
        end
    endtask

    task automatic write_reg(input logic [4:0] addr, input logic [31:0] data);
        @(posedge clk);
        #1;
        wb = '{we: 1'b1, addr: addr, data: data};
    endtask

    task automatic run_row(input int idx);
        row_t r;
        logic acc;
        r = rows[idx];
        cur_idx = idx;
        row_errs = 0;
        if (!r.hold) begin
            @(posedge clk);
            #1;
            fs_valid = 1'b1;
            fs_pkt = {r.inst, r.pc};
            do begin
                @(negedge clk);
                acc = ds_allowin;
                @(posedge clk);
            end while (!acc);
            #1;
            // behind a taken branch fetch keeps offering, and that one must die
            fs_valid = r.exp_taken;
            fs_pkt = {enc_3r(`OP5_ADD, 5'd2, 5'd1, 5'd7), r.pc + 32'd4};
        end else begin
            @(posedge clk);
            #1;
        end
        es_fwd = r.es;
        ms_fwd = r.ms;
        ws_fwd = r.ws;
        es_is_load = r.load;
        es_allowin = r.allow;
        @(negedge clk);
        compare("ds_valid_out", 32'(ds_valid_out), 32'(r.exp_valid));
        compare("ds_allowin", 32'(ds_allowin), 32'(r.exp_allowin));
        compare("alu_op", 32'(issue_pkt.alu_op), 32'(r.exp_op));
        compare("alu_src1", issue_pkt.alu_src1, r.exp_src1);
        compare("alu_src2", issue_pkt.alu_src2, r.exp_src2);
        compare("store_data", issue_pkt.store_data, r.exp_store);
        compare("dest", 32'(issue_pkt.dest), 32'(r.exp_dest));
        compare("gr_we", 32'(issue_pkt.gr_we), 32'(r.exp_gr_we));
        compare("mem", 32'({issue_pkt.res_from_mem, issue_pkt.mem_we}), 32'(r.exp_mem));
        compare("pc", issue_pkt.pc, r.pc);
        compare("br.taken", 32'(br.taken), 32'(r.exp_taken));
        if (r.exp_taken) begin
            compare("br.target", br.target, r.exp_target);
            @(posedge clk);
            #1;
            fs_valid = 1'b0;
            @(negedge clk);
            compare("valid after kill", 32'(ds_valid_out), 32'd0);
        end
        if (row_errs == 0) begin
            $display("row %0d passed", idx);
            passed++;
        end else begin
            $display("row %0d failed with %0d mismatches", idx, row_errs);
            failed++;
        end
    endtask

    initial begin
        reset = 1'b1;
        fs_valid = 1'b0;
        fs_pkt = '0;
        es_allowin = 1'b1;
        es_fwd = '0;
        ms_fwd = '0;
        ws_fwd = '0;
        es_is_load = 1'b0;
        wb = '0;
        build_table();
        limit = 20 * rows.size() + RESET_CYCLES + 16;
        repeat (RESET_CYCLES) @(posedge clk);
        #1;
        reset = 1'b0;
        @(negedge clk);
        if (ds_valid_out !== 1'b0 || br.taken !== 1'b0 || ds_allowin !== 1'b1) begin
            $display("error at %0d ns: stage outputs not idle after reset", $time);
            failed++;
        end
        write_reg(5'd1, 32'h0000_0010);
        write_reg(5'd2, 32'h0000_0003);
        write_reg(5'd3, 32'hffff_fff0);
        write_reg(5'd4, 32'h0000_0010);
        write_reg(5'd5, 32'h1234_5678);
        write_reg(5'd6, 32'h0000_1000);
        @(posedge clk);
        #1;
        wb = '0;
        for (int i = 0; i < rows.size(); i++) begin
            run_row(i);
        end
        $display("rows %0d, passed %0d, failed %0d", rows.size(), passed, failed);
        if (failed == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

// ==== list.f ====
+incdir+.
decode_pkg.sv
fetch_latch.sv
inst_decoder.sv
reg_file.sv
operand_bypass.sv
branch_unit.sv
issue_control.sv
decode_stage.sv
tb_decode_stage.sv

// ==== Makefile ====
VERILATOR ?= verilator
FLAGS     ?= --timing
TOP       ?= tb_decode_stage
RTL_TOP   ?= decode_stage
FILELIST  ?= list.f
OBJ_DIR   ?= obj_dir

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) --binary $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) | tee /dev/stderr | grep -qF '=== PASS ==='

clean:
	rm -rf $(OBJ_DIR)
